// File: debug_mam.f
source/mam_pkg.sv
source/mam_cmd_parser.sv
source/mam_write_path.sv
source/mam_resp_gen.sv
source/mam_ctrl.sv
source/debug_mam.sv
testbench/tb_debug_mam.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the debug_mam testbench with Verilator, then scan the log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_debug_mam -f debug_mam.f -o tb_debug_mam > build.log 2>&1 ||
  { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_debug_mam > sim.log 2>&1 || echo "Simulator exited with an error"
cat sim.log
grep -q "Test FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "Test OK" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"

// File: source/debug_mam.sv
// Debug memory access top level joining parser, controller, write path and responder
`timescale 1ns/1ps
`default_nettype none

module debug_mam #(
  parameter int DATA_WIDTH  = 32,
  parameter int ADDR_WIDTH  = 32,
  parameter int MAX_PKT_LEN = 8
) (
  input  wire logic                            clk,
  input  wire logic                            rst,
  input  wire mam_pkg::flit_t                  debug_in,
  output logic                                 debug_in_ready,
  output mam_pkg::flit_t                       debug_out,
  input  wire logic                            debug_out_ready,
  input  wire logic [mam_pkg::FLIT_WIDTH-1:0]  id,
  output logic                                 req_valid,
  input  wire logic                            req_ready,
  output logic                                 req_we,
  output logic [ADDR_WIDTH-1:0]                req_addr,
  output logic                                 req_burst,
  output logic [mam_pkg::BEATS_WIDTH-1:0]      req_beats,
  output logic                                 req_sync,
  output logic                                 write_valid,
  output logic [DATA_WIDTH-1:0]                write_data,
  output logic [DATA_WIDTH/8-1:0]              write_strb,
  input  wire logic                            write_ready,
  input  wire logic                            write_complete,
  input  wire logic                            read_valid,
  input  wire logic [DATA_WIDTH-1:0]           read_data,
  output logic                                 read_ready
);
  import mam_pkg::*;

  mam_cmd_t   cmd;
  mam_req_t   req;
  logic       cmd_done;
  logic       parse_start;
  logic       parse_ready;
  logic       write_start;
  logic       write_done;
  logic       wp_ready;
  logic       resp_start;
  logic       resp_done;
  logic [1:0] in_sel;

  mam_cmd_parser #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) parser_inst (
    .clk, .rst, .start(parse_start), .flit_in(debug_in), .flit_ready(parse_ready),
    .cmd, .cmd_done
  );

  mam_ctrl #(.ADDR_WIDTH(ADDR_WIDTH)) ctrl_inst (
    .clk, .rst, .cmd, .cmd_done, .parse_start, .req_valid, .req_ready, .req,
    .write_start, .write_done, .write_complete, .resp_start, .resp_done, .in_sel
  );

  mam_write_path #(.DATA_WIDTH(DATA_WIDTH)) write_path_inst (
    .clk, .rst, .start(write_start), .cmd, .flit_in(debug_in), .flit_ready(wp_ready),
    .write_valid, .write_data, .write_ready, .done(write_done)
  );

  mam_resp_gen #(.DATA_WIDTH(DATA_WIDTH), .MAX_PKT_LEN(MAX_PKT_LEN)) resp_gen_inst (
    .clk, .rst, .start(resp_start), .is_read(!req.we), .di_src(cmd.di_src),
    .beats(req.beats), .id, .read_valid, .read_data, .read_ready,
    .flit_out(debug_out), .flit_out_ready(debug_out_ready), .done(resp_done)
  );

  // Parser owns the input in PARSE, write path in WRITE
  assign debug_in_ready = (in_sel[0] && parse_ready) || (in_sel[1] && wp_ready);

  assign req_we     = req.we;
  assign req_addr   = req.addr[ADDR_WIDTH-1:0];
  assign req_burst  = req.burst;
  assign req_beats  = req.beats;
  assign req_sync   = req.sync;
  assign write_strb = cmd.strb[DATA_WIDTH/8-1:0];   // From the header flit

endmodule

`default_nettype wire

// File: source/mam_cmd_parser.sv
// Command parser that decodes the routing, command and address flits of a packet
`timescale 1ns/1ps
`default_nettype none

module mam_cmd_parser #(
  parameter int ADDR_WIDTH = 32,
  parameter int DATA_WIDTH = 32
) (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              start,
  input  wire mam_pkg::flit_t    flit_in,
  output logic                   flit_ready,
  output mam_pkg::mam_cmd_t      cmd,
  output logic                   cmd_done
);
  import mam_pkg::*;

  localparam int ADDR_WORDS = ADDR_WIDTH / FLIT_WIDTH;
  localparam int HDR_IDX    = DI_HDR_FLITS;               // Command header flit
  localparam int LAST_IDX   = DI_HDR_FLITS + ADDR_WORDS;  // Final address flit
  localparam int STRB_BITS  = DATA_WIDTH / 8;

  logic [3:0] idx;   // Flit position within the command
  logic       busy;
  logic       take;

  assign flit_ready = busy;
  assign take       = busy && flit_in.valid;

  ////////////////////////////////////////////////////////////
  // Flit counter
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      busy     <= 1'b0;
      idx      <= '0;
      cmd_done <= 1'b0;
    end else begin
      cmd_done <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        idx  <= '0;
      end else if (take) begin
        idx <= idx + 4'd1;
        if (idx == 4'(LAST_IDX)) begin
          busy     <= 1'b0;
          cmd_done <= 1'b1;   // Seen one cycle after the last address flit
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Field capture
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (start) begin
      cmd.addr <= '0;   // Upper bits stay clear for narrow addresses
    end else if (take) begin
      if (idx == 4'd1) begin
        cmd.di_src <= flit_in.data;
      end
      if (idx == 4'(HDR_IDX)) begin
        cmd.we    <= flit_in.data[15];
        cmd.burst <= flit_in.data[14];
        cmd.sync  <= flit_in.data[13];
        cmd.strb  <= 8'(flit_in.data[STRB_BITS-1:0]);
        // Single access is always one beat
        cmd.beats <= flit_in.data[14] ? BEATS_WIDTH'(flit_in.data[7:0]) : BEATS_WIDTH'(1);
      end
      if (idx > 4'(HDR_IDX)) begin
        cmd.addr <= {cmd.addr[63-FLIT_WIDTH:0], flit_in.data};   // MS flit first
      end
      if (idx == 4'(LAST_IDX)) begin
        cmd.pkt_open <= !flit_in.last;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/mam_ctrl.sv
// Controller FSM that sequences parse, request, write, sync wait and response
`timescale 1ns/1ps
`default_nettype none

module mam_ctrl #(
  parameter int ADDR_WIDTH = 32
) (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire mam_pkg::mam_cmd_t cmd,
  input  wire logic              cmd_done,
  output logic                   parse_start,
  output logic                   req_valid,
  input  wire logic              req_ready,
  output mam_pkg::mam_req_t      req,
  output logic                   write_start,
  input  wire logic              write_done,
  input  wire logic              write_complete,
  output logic                   resp_start,
  input  wire logic              resp_done,
  output logic [1:0]             in_sel
);
  import mam_pkg::*;

  mam_state_e state;
  mam_state_e state_next;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next  = state;
    parse_start = 1'b0;
    write_start = 1'b0;
    resp_start  = 1'b0;
    case (state)
      IDLE: begin
        parse_start = 1'b1;   // Arm the parser for the next command
        state_next  = PARSE;
      end
      PARSE: begin
        if (cmd_done) state_next = REQUEST;
      end
      REQUEST: begin
        if (req_ready) begin
          if (req.we) begin
            write_start = 1'b1;
            state_next  = WRITE;
          end else begin
            resp_start = 1'b1;
            state_next = RESPOND;
          end
        end
      end
      WRITE: begin
        if (write_done) state_next = req.sync ? SYNC_WAIT : IDLE;
      end
      SYNC_WAIT: begin
        if (write_complete) begin
          resp_start = 1'b1;   // Event packet only
          state_next = RESPOND;
        end
      end
      RESPOND: begin
        if (resp_done) state_next = IDLE;
      end
      default: state_next = IDLE;
    endcase
  end

  assign req_valid = (state == REQUEST);
  assign in_sel    = {state == WRITE, state == PARSE};   // Input stream owner

  // Request fields held steady through the handshake
  always_ff @(posedge clk) begin
    if (state == PARSE && cmd_done) begin
      req.we    <= cmd.we;
      req.burst <= cmd.burst;
      req.sync  <= cmd.sync;
      req.beats <= cmd.beats;
      req.addr  <= 64'(cmd.addr[ADDR_WIDTH-1:0]);
    end
  end

endmodule

`default_nettype wire

// File: source/mam_pkg.sv
// Debug memory access shared types, flit format and protocol constants
`default_nettype none

package mam_pkg;

  localparam int FLIT_WIDTH   = 16;
  localparam int BEATS_WIDTH  = 13;
  localparam int DI_HDR_FLITS = 3;   // Destination, source, flags

  // Event packet type, subtype 0, reserved bits clear
  localparam logic [FLIT_WIDTH-1:0] EVENT_FLAGS = 16'h8000;

  typedef struct packed {
    logic                  valid;
    logic                  last;
    logic [FLIT_WIDTH-1:0] data;
  } flit_t;

  typedef struct packed {
    logic                   we;
    logic                   burst;
    logic                   sync;
    logic [7:0]             strb;      // Low DATA_WIDTH/8 bits used
    logic [BEATS_WIDTH-1:0] beats;
    logic [63:0]            addr;      // Low ADDR_WIDTH bits used
    logic [FLIT_WIDTH-1:0]  di_src;    // Requester id
    logic                   pkt_open;  // Packet continues after the address
  } mam_cmd_t;

  // Fields presented on the memory request channel
  typedef struct packed {
    logic                   we;
    logic                   burst;
    logic                   sync;
    logic [BEATS_WIDTH-1:0] beats;
    logic [63:0]            addr;
  } mam_req_t;

  typedef enum logic [2:0] {IDLE, PARSE, REQUEST, WRITE, SYNC_WAIT, RESPOND} mam_state_e;

endpackage

`default_nettype wire

// File: source/mam_resp_gen.sv
// Response generator for read data packets and sync write event packets
`timescale 1ns/1ps
`default_nettype none

module mam_resp_gen #(
  parameter int DATA_WIDTH  = 32,
  parameter int MAX_PKT_LEN = 8
) (
  input  wire logic                            clk,
  input  wire logic                            rst,
  input  wire logic                            start,
  input  wire logic                            is_read,
  input  wire logic [mam_pkg::FLIT_WIDTH-1:0]  di_src,
  input  wire logic [mam_pkg::BEATS_WIDTH-1:0] beats,
  input  wire logic [mam_pkg::FLIT_WIDTH-1:0]  id,
  input  wire logic                            read_valid,
  input  wire logic [DATA_WIDTH-1:0]           read_data,
  output logic                                 read_ready,
  output mam_pkg::flit_t                       flit_out,
  input  wire logic                            flit_out_ready,
  output logic                                 done
);
  import mam_pkg::*;

  localparam int WORD_FLITS = DATA_WIDTH / FLIT_WIDTH;
  localparam int WCNT_W     = (WORD_FLITS > 1) ? $clog2(WORD_FLITS) : 1;
  localparam int PCNT_W     = $clog2(MAX_PKT_LEN + 1);

  logic                   active;
  logic                   read_q;       // Read response, else sync event
  logic [PCNT_W-1:0]      pcnt;         // Flit within the outgoing packet
  logic [WCNT_W-1:0]      wcnt;         // Flit within the read word
  logic [BEATS_WIDTH-1:0] beats_left;
  logic                   in_hdr;
  logic                   word_last;
  logic                   pkt_full;
  logic                   final_flit;
  logic                   fire;

  assign in_hdr     = pcnt < PCNT_W'(DI_HDR_FLITS);
  assign word_last  = wcnt == WCNT_W'(WORD_FLITS - 1);
  assign pkt_full   = pcnt == PCNT_W'(MAX_PKT_LEN - 1);
  assign final_flit = word_last && (beats_left == BEATS_WIDTH'(1));

  ////////////////////////////////////////////////////////////
  // Outgoing flit
  ////////////////////////////////////////////////////////////

  always_comb begin
    flit_out = '0;
    if (active && in_hdr) begin
      flit_out.valid = 1'b1;
      case (pcnt)
        PCNT_W'(0): flit_out.data = di_src;   // Back to the requester
        PCNT_W'(1): flit_out.data = id;
        default:    flit_out.data = EVENT_FLAGS;
      endcase
      // Event packet is the header alone
      flit_out.last = !read_q && (pcnt == PCNT_W'(DI_HDR_FLITS - 1));
    end else if (active) begin
      flit_out.valid = read_valid;
      flit_out.data  = read_data[FLIT_WIDTH*(WORD_FLITS-1-int'(wcnt)) +: FLIT_WIDTH];
      flit_out.last  = pkt_full || final_flit;
    end
  end

  assign fire       = flit_out.valid && flit_out_ready;
  assign read_ready = fire && !in_hdr && word_last;   // Word fully sent

  ////////////////////////////////////////////////////////////
  // Counters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      active     <= 1'b0;
      read_q     <= 1'b0;
      pcnt       <= '0;
      wcnt       <= '0;
      beats_left <= '0;
      done       <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        active     <= 1'b1;
        read_q     <= is_read;
        pcnt       <= '0;
        wcnt       <= '0;
        beats_left <= beats;
      end else if (fire) begin
        pcnt <= flit_out.last ? '0 : pcnt + 1'b1;   // Reopen with a fresh header
        if (!in_hdr) begin
          wcnt <= word_last ? '0 : wcnt + 1'b1;
          if (word_last) begin
            beats_left <= beats_left - 1'b1;
          end
        end
        if (flit_out.last && (in_hdr || final_flit)) begin
          active <= 1'b0;
          done   <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: source/mam_write_path.sv
// Write path that packs flits into data words and drives the write handshake
`timescale 1ns/1ps
`default_nettype none

module mam_write_path #(
  parameter int DATA_WIDTH = 32
) (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              start,
  input  wire mam_pkg::mam_cmd_t cmd,
  input  wire mam_pkg::flit_t    flit_in,
  output logic                   flit_ready,
  output logic                   write_valid,
  output logic [DATA_WIDTH-1:0]  write_data,
  input  wire logic              write_ready,
  output logic                   done
);
  import mam_pkg::*;

  localparam int WORD_FLITS = DATA_WIDTH / FLIT_WIDTH;
  localparam int WCNT_W     = (WORD_FLITS > 1) ? $clog2(WORD_FLITS) : 1;

  logic                   active;
  logic                   in_pkt;     // Routing header of current packet consumed
  logic [1:0]             hdr_cnt;
  logic [WCNT_W-1:0]      wcnt;       // Flit within the word
  logic [BEATS_WIDTH-1:0] beats_left;
  logic                   held;       // Full word waiting on write_ready
  logic [DATA_WIDTH-1:0]  word_q;
  logic [DATA_WIDTH-1:0]  word_next;
  logic                   take;
  logic                   take_data;
  logic                   word_end;
  logic                   beat_done;

  assign flit_ready = active && !held;   // Intake frozen while a word is held
  assign take       = flit_ready && flit_in.valid;
  assign take_data  = take && in_pkt;
  assign word_end   = take_data && (wcnt == WCNT_W'(WORD_FLITS - 1));

  // Merge the incoming flit into its slot, most significant first
  always_comb begin
    word_next = word_q;
    word_next[FLIT_WIDTH*(WORD_FLITS-1-int'(wcnt)) +: FLIT_WIDTH] = flit_in.data;
  end

  assign write_valid = held || word_end;
  assign write_data  = held ? word_q : word_next;
  assign beat_done   = write_valid && write_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      active     <= 1'b0;
      in_pkt     <= 1'b0;
      hdr_cnt    <= '0;
      wcnt       <= '0;
      beats_left <= '0;
      held       <= 1'b0;
      done       <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        active     <= 1'b1;
        in_pkt     <= cmd.pkt_open;   // Closed packet means a new header comes first
        hdr_cnt    <= '0;
        wcnt       <= '0;
        beats_left <= cmd.beats;
        held       <= 1'b0;
      end else begin
        // Skip destination, source and flags of a continuation packet
        if (take && !in_pkt) begin
          hdr_cnt <= hdr_cnt + 2'd1;
          if (hdr_cnt == 2'(DI_HDR_FLITS - 1)) begin
            hdr_cnt <= '0;
            in_pkt  <= 1'b1;
          end
        end
        if (take_data) begin
          wcnt   <= word_end ? '0 : wcnt + 1'b1;
          in_pkt <= !flit_in.last;
        end
        if (word_end && !write_ready) begin
          held <= 1'b1;
        end
        if (beat_done) begin
          held       <= 1'b0;
          beats_left <= beats_left - 1'b1;
          if (beats_left == BEATS_WIDTH'(1)) begin
            active <= 1'b0;
            done   <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take_data) begin
      word_q <= word_next;
    end
  end

endmodule

`default_nettype wire

// File: testbench/tb_debug_mam.sv
// Testbench for the debug memory access module with a memory model and packet checks
`timescale 1ns/1ps
`default_nettype none

module tb_debug_mam;
  import mam_pkg::*;

  localparam int DATA_WIDTH  = 32;
  localparam int ADDR_WIDTH  = 32;
  localparam int MAX_PKT_LEN = 8;
  localparam int WORD_FLITS  = DATA_WIDTH / 16;
  localparam int WORD_BYTES  = DATA_WIDTH / 8;
  localparam int NROWS       = 8;
  localparam int TIMEOUT     = 400 * NROWS;   // Cycles for the whole table
  localparam logic [15:0] MOD_ID = 16'h0A05;
  localparam logic [15:0] DEST   = 16'h0003;

  typedef struct packed {
    logic                  we;
    logic                  burst;
    logic                  sync;
    logic [ADDR_WIDTH-1:0] addr;
    logic [7:0]            beats;   // Burst only
    logic [3:0]            strb;    // Single only
    logic                  split;   // Close the packet after the address
    logic [15:0]           seed;
  } row_t;

  logic                   clk;
  logic                   rst;
  flit_t                  debug_in;
  logic                   debug_in_ready;
  flit_t                  debug_out;
  logic                   debug_out_ready;
  logic [15:0]            id;
  logic                   req_valid;
  logic                   req_ready;
  logic                   req_we;
  logic [ADDR_WIDTH-1:0]  req_addr;
  logic                   req_burst;
  logic [BEATS_WIDTH-1:0] req_beats;
  logic                   req_sync;
  logic                   write_valid;
  logic [DATA_WIDTH-1:0]  write_data;
  logic [WORD_BYTES-1:0]  write_strb;
  logic                   write_ready;
  logic                   write_complete;
  logic                   read_valid;
  logic [DATA_WIDTH-1:0]  read_data;
  logic                   read_ready;

  row_t                  rows [NROWS];
  row_t                  cur;                                    // Command in flight
  logic [DATA_WIDTH-1:0] mem    [logic [ADDR_WIDTH-1:0]];        // Written by the DUT
  logic [DATA_WIDTH-1:0] golden [logic [ADDR_WIDTH-1:0]];        // Expected contents
  logic [16:0]           exp_q [$];                              // {last, data}
  int                    req_count;
  int                    wr_left;
  int                    wr_beat;
  int                    rd_left;
  int                    rd_beat;
  logic [ADDR_WIDTH-1:0] rd_addr;
  int                    wc_count;   // Cycles until write_complete, -1 when idle
  logic                  wc_drop;
  int                    cycles;

  debug_mam #(
    .DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH), .MAX_PKT_LEN(MAX_PKT_LEN)
  ) debug_mam_inst (
    .clk, .rst, .debug_in, .debug_in_ready, .debug_out, .debug_out_ready, .id,
    .req_valid, .req_ready, .req_we, .req_addr, .req_burst, .req_beats, .req_sync,
    .write_valid, .write_data, .write_strb, .write_ready, .write_complete,
    .read_valid, .read_data, .read_ready
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Reference helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [15:0] src_of(input int i);
    return 16'h0100 + 16'(i);
  endfunction

  function automatic logic [DATA_WIDTH-1:0] data_word(input logic [15:0] seed, input int beat);
    return {seed ^ 16'(beat * 257), seed + 16'(beat)};
  endfunction

  // Unwritten locations read back as the rotated, inverted address
  function automatic logic [DATA_WIDTH-1:0] fill_word(input logic [ADDR_WIDTH-1:0] addr);
    return ~{addr[7:0], addr[ADDR_WIDTH-1:8]};
  endfunction

  function automatic logic [DATA_WIDTH-1:0] mem_word(input logic [ADDR_WIDTH-1:0] addr);
    return mem.exists(addr) ? mem[addr] : fill_word(addr);
  endfunction

  function automatic logic [DATA_WIDTH-1:0] exp_word(input logic [ADDR_WIDTH-1:0] addr);
    return golden.exists(addr) ? golden[addr] : fill_word(addr);
  endfunction

  function automatic void queue_header(input logic [15:0] src, input logic close);
    exp_q.push_back({1'b0, src});
    exp_q.push_back({1'b0, MOD_ID});
    exp_q.push_back({close, EVENT_FLAGS});
  endfunction

  function automatic void queue_read_resp(input logic [15:0] src,
                                          input logic [ADDR_WIDTH-1:0] addr, input int beats);
    logic [DATA_WIDTH-1:0] w;
    logic                  close;
    int                    n;
    int                    k;
    int                    f;
    n = 0;
    for (k = 0; k < beats; k++) begin
      w = exp_word(addr + ADDR_WIDTH'(k * WORD_BYTES));
      for (f = 0; f < WORD_FLITS; f++) begin
        if (n == 0) begin
          queue_header(src, 1'b0);   // Fresh header for each packet
          n = 3;
        end
        n     = n + 1;
        close = (k == beats - 1 && f == WORD_FLITS - 1) || n == MAX_PKT_LEN;
        exp_q.push_back({close, w[DATA_WIDTH - 16 * (f + 1) +: 16]});
        if (close) n = 0;
      end
    end
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1);
  endtask

  ////////////////////////////////////////////////////////////
  // Packet driver
  ////////////////////////////////////////////////////////////

  task automatic send_flit(input logic [15:0] data, input logic last);
    while ($urandom_range(4) == 0) begin   // Idle gap on the input
      @(posedge clk);
      #1;
    end
    debug_in = {1'b1, last, data};
    @(negedge clk);
    while (!debug_in_ready) @(negedge clk);
    @(posedge clk);
    #1;
    debug_in = '0;
  endtask

  task automatic send_row(input int i);
    row_t                  r;
    logic [15:0]           hdr;
    logic [DATA_WIDTH-1:0] w;
    logic                  close;
    int                    total;
    int                    n;
    int                    k;
    r     = rows[i];
    hdr   = {r.we, r.burst, r.sync, 5'b0, r.burst ? r.beats : {4'b0, r.strb}};
    total = r.we ? (r.burst ? int'(r.beats) : 1) * WORD_FLITS : 0;
    send_flit(DEST, 1'b0);
    send_flit(src_of(i), 1'b0);
    send_flit(16'h0000, 1'b0);   // Flags
    send_flit(hdr, 1'b0);
    for (k = ADDR_WIDTH / 16 - 1; k >= 0; k--) begin
      send_flit(r.addr[16*k +: 16], k == 0 && (total == 0 || r.split));
    end
    n = 0;
    for (k = 0; k < total; k++) begin
      if (r.split && n == 0) begin   // Continuation packet header
        send_flit(DEST, 1'b0);
        send_flit(src_of(i), 1'b0);
        send_flit(16'h0000, 1'b0);
      end
      w     = data_word(r.seed, k / WORD_FLITS);
      close = (k == total - 1) || (r.split && n == 2);
      send_flit(w[DATA_WIDTH - 16 * (k % WORD_FLITS + 1) +: 16], close);
      n = (n == 2) ? 0 : n + 1;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Checkers
  ////////////////////////////////////////////////////////////

  task automatic check_request();
    int beats;
    int k;
    assert (req_count < NROWS) else stop_run("request seen after the last table row");
    assert (exp_q.size() == 0 && wr_left == 0 && rd_left == 0)
      else stop_run("request started before the previous command ended");
    cur   = rows[req_count];
    beats = cur.burst ? int'(cur.beats) : 1;
    assert (req_we == cur.we)
      else stop_run($sformatf("MISMATCH req_we got %h expected %h", req_we, cur.we));
    assert (req_addr == cur.addr)
      else stop_run($sformatf("MISMATCH req_addr got %h expected %h", req_addr, cur.addr));
    assert (req_burst == cur.burst)
      else stop_run($sformatf("MISMATCH req_burst got %h expected %h", req_burst, cur.burst));
    assert (req_beats == BEATS_WIDTH'(beats))
      else stop_run($sformatf("MISMATCH req_beats got %h expected %h", req_beats, beats));
    assert (req_sync == cur.sync)
      else stop_run($sformatf("MISMATCH req_sync got %h expected %h", req_sync, cur.sync));
    if (cur.we) begin
      wr_left = beats;
      wr_beat = 0;
      for (k = 0; k < beats; k++) begin
        golden[cur.addr + ADDR_WIDTH'(k * WORD_BYTES)] = data_word(cur.seed, k);
      end
      if (cur.sync) queue_header(src_of(req_count), 1'b1);   // Event packet
    end else begin
      rd_left = beats;
      rd_beat = 0;
      rd_addr = cur.addr;
      queue_read_resp(src_of(req_count), cur.addr, beats);
    end
    req_count = req_count + 1;
  endtask

  task automatic check_write();
    logic [DATA_WIDTH-1:0] exp_data;
    logic [7:0]            hdr_low;
    assert (wr_left > 0) else stop_run("write beat with no write outstanding");
    exp_data = data_word(cur.seed, wr_beat);
    hdr_low  = cur.burst ? cur.beats : {4'b0, cur.strb};   // Strobe shares the count bits
    assert (write_data == exp_data)
      else stop_run($sformatf("MISMATCH write_data got %h expected %h", write_data, exp_data));
    assert (write_strb == hdr_low[WORD_BYTES-1:0])
      else stop_run($sformatf("MISMATCH write_strb got %h expected %h",
                              write_strb, hdr_low[WORD_BYTES-1:0]));
    mem[cur.addr + ADDR_WIDTH'(wr_beat * WORD_BYTES)] = write_data;
    wr_beat = wr_beat + 1;
    wr_left = wr_left - 1;
    if (wr_left == 0 && cur.sync) wc_count = $urandom_range(5);
  endtask

  task automatic check_flit();
    logic [16:0] e;
    assert (exp_q.size() > 0) else stop_run("outgoing flit when no packet was expected");
    e = exp_q.pop_front();
    assert (debug_out.data == e[15:0])
      else stop_run($sformatf("MISMATCH debug_out.data got %h expected %h",
                              debug_out.data, e[15:0]));
    assert (debug_out.last == e[16])
      else stop_run($sformatf("MISMATCH debug_out.last got %h expected %h",
                              debug_out.last, e[16]));
    if (cur.we) begin
      assert (write_complete) else stop_run("event flit sent before write_complete");
      if (exp_q.size() == 0) wc_drop = 1'b1;
    end
  endtask

  // Handshakes sampled mid cycle, inputs are steady by then
  always @(negedge clk) begin
    if (rst === 1'b0) begin
      if (req_valid && req_ready) check_request();
      if (write_valid && write_ready) check_write();
      if (read_ready) begin
        assert (read_valid) else stop_run("read_ready pulsed while read_valid was low");
        rd_beat = rd_beat + 1;
        rd_left = rd_left - 1;
      end
      if (debug_out.valid && debug_out_ready) check_flit();
    end
  end

  ////////////////////////////////////////////////////////////
  // Memory model and random stalls
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    #1;
    req_ready       = ($urandom_range(3) != 0);
    write_ready     = ($urandom_range(3) != 0);
    debug_out_ready = ($urandom_range(3) != 0);
    read_valid      = (rd_left > 0) && ($urandom_range(3) != 0);
    read_data       = mem_word(rd_addr + ADDR_WIDTH'(rd_beat * WORD_BYTES));
    if (wc_drop) begin
      write_complete = 1'b0;
      wc_drop        = 1'b0;
    end
    if (wc_count == 0) begin
      write_complete = 1'b1;
      wc_count       = -1;
    end else if (wc_count > 0) begin
      wc_count = wc_count - 1;
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    assert (cycles < TIMEOUT) else stop_run("timeout waiting for the DUT to finish the table");
  end

  initial begin
    int i;
    void'($urandom(44));
    rst             = 1'b1;
    debug_in        = '0;
    debug_out_ready = 1'b0;
    id              = MOD_ID;
    req_ready       = 1'b0;
    write_ready     = 1'b0;
    write_complete  = 1'b0;
    read_valid      = 1'b0;
    read_data       = '0;
    req_count       = 0;
    wr_left         = 0;
    wr_beat         = 0;
    rd_left         = 0;
    rd_beat         = 0;
    rd_addr         = '0;
    wc_count        = -1;
    wc_drop         = 1'b0;
    cycles          = 0;
    //          we    burst sync  addr           beats strb  split seed
    rows[0] = '{1'b1, 1'b0, 1'b0, 32'h0000_1000, 8'd1, 4'h6, 1'b0, 16'h1A2B};   // Single write
    rows[1] = '{1'b1, 1'b1, 1'b0, 32'h0000_2000, 8'd5, 4'h0, 1'b1, 16'h3C4D};
    rows[2] = '{1'b0, 1'b1, 1'b0, 32'h0000_2000, 8'd6, 4'h0, 1'b0, 16'h0000};   // Burst read
    rows[3] = '{1'b1, 1'b0, 1'b1, 32'h0000_3000, 8'd1, 4'hF, 1'b0, 16'h5E6F};
    rows[4] = '{1'b0, 1'b0, 1'b0, 32'h0000_1000, 8'd1, 4'h0, 1'b0, 16'h0000};
    rows[5] = '{1'b1, 1'b0, 1'b1, 32'h0000_3004, 8'd1, 4'h3, 1'b1, 16'h7081};   // Split sync
    rows[6] = '{1'b0, 1'b1, 1'b0, 32'h0000_3000, 8'd3, 4'h0, 1'b0, 16'h0000};
    rows[7] = '{1'b1, 1'b1, 1'b1, 32'h0000_4000, 8'd4, 4'h0, 1'b0, 16'h92A3};
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    for (i = 0; i < NROWS; i++) begin
      send_row(i);
    end
    while (req_count < NROWS || wr_left != 0 || rd_left != 0 || exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (20) @(posedge clk);   // Room for a stray flit to show up
    if (debug_in_ready) begin
      $display("Test OK");
      $finish;
    end else begin
      stop_run("DUT did not return to accepting a new command after the last one");
    end
  end

endmodule

`default_nettype wire
